//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sim.f

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_checker.sv
`include "hub_defs.svh"

module tb_checker;
  timeunit 1ns;
  timeprecision 100ps;
  import hub_types_pkg::*;
  import owner_pkg::*;

  string names[6] = '{"queue_order", "queue_full_empty", "app_data_priority",
                      "buffer_token_handoff", "enable_gating", "rx_len_latch"};
  int checks[6];
  int errors[6];
  byte_t tx_q[$];
  byte_t rx_q[$];
  app_grant_e app_st;
  // token order is app rx, UDP rx, UDP tx
  owner_e owner[3];
  app_len_t len;

  function automatic void check(input int t, input string what, input logic [31:0] exp,
                                input logic [31:0] act);
    checks[t]++;
    if (act !== exp) begin
      errors[t]++;
      $display("error %s %s: expected %0h, actual %0h", names[t], what, exp, act);
    end
  endfunction

  function automatic void check_queue(input string what, input byte_t q[$], input int depth,
                                      input logic full, input logic empty, input byte_t dout);
    check(1, {what, " full"}, 32'(q.size() == depth), 32'(full));
    check(1, {what, " empty"}, 32'(q.size() == 0), 32'(empty));
    if (q.size() > 0) begin
      check(0, {what, " head"}, 32'(q[0]), 32'(dout));
    end
  endfunction

  // a low enable moves the comparison into the gating test
  function automatic void check_grants(input int t, input string what, input logic en,
                                       input logic exp_ip, input logic exp_cpu,
                                       input logic ip_g, input logic cpu_g);
    int tt;
    tt = en ? t : 4;
    check(tt, {what, " ip grant"}, 32'(en && exp_ip), 32'(ip_g));
    check(tt, {what, " cpu grant"}, 32'(en && exp_cpu), 32'(cpu_g));
  endfunction

  always @(negedge tb_top.clk) begin
    logic [2:0] ip_rel;
    logic [2:0] cpu_rel;
    logic tx_push;
    logic rx_push;
    if (!tb_top.rst_n) begin
      tx_q.delete();
      rx_q.delete();
      app_st = GRANT_NONE;
      owner = '{OWNER_IP, OWNER_IP, OWNER_CPU};
      len = '0;
    end else begin
      ip_rel = {tb_top.i_udptx_ip_rel, tb_top.i_udprx_ip_rel, tb_top.i_apprx_ip_rel};
      cpu_rel = {tb_top.i_udptx_cpu_rel, tb_top.i_udprx_cpu_rel, tb_top.i_apprx_cpu_rel};
      check_queue("tx", tx_q, `HUB_TX_QUEUE_DEPTH, tb_top.o_tx_full, tb_top.o_tx_empty,
                  tb_top.o_tx_dout);
      check_queue("rx", rx_q, `HUB_RX_QUEUE_DEPTH, tb_top.o_rx_full, tb_top.o_rx_empty,
                  tb_top.o_rx_dout);
      check_grants(2, "app", tb_top.i_ether_en, app_st == GRANT_IP, app_st == GRANT_CPU,
                   tb_top.o_app_ip_grant, tb_top.o_app_cpu_grant);
      check_grants(3, "apprx", tb_top.i_ros2_en, owner[0] == OWNER_IP,
                   owner[0] == OWNER_CPU, tb_top.o_apprx_ip_grant, tb_top.o_apprx_cpu_grant);
      check_grants(3, "udprx", tb_top.i_ether_en, owner[1] == OWNER_IP,
                   owner[1] == OWNER_CPU, tb_top.o_udprx_ip_grant, tb_top.o_udprx_cpu_grant);
      check_grants(3, "udptx", tb_top.i_ether_en, owner[2] == OWNER_IP,
                   owner[2] == OWNER_CPU, tb_top.o_udptx_ip_grant, tb_top.o_udptx_cpu_grant);
      check(5, "rx_len", 32'(len), 32'(tb_top.o_rx_len));

      // *************************************************
      // model step for the coming rising edge
      // *************************************************
      tx_push = tb_top.i_tx_wr_en && (tx_q.size() < `HUB_TX_QUEUE_DEPTH);
      rx_push = tb_top.i_rx_wr_en && (rx_q.size() < `HUB_RX_QUEUE_DEPTH);
      if (tb_top.i_tx_rd_en && tx_q.size() > 0) begin
        void'(tx_q.pop_front());
      end
      if (tb_top.i_rx_rd_en && rx_q.size() > 0) begin
        void'(rx_q.pop_front());
      end
      if (tx_push) begin
        tx_q.push_back(tb_top.i_tx_din);
      end
      if (rx_push) begin
        rx_q.push_back(tb_top.i_rx_din);
      end
      case (app_st)
        GRANT_NONE: begin
          app_st = tb_top.i_app_ip_req ? GRANT_IP :
                   (tb_top.i_app_cpu_req ? GRANT_CPU : GRANT_NONE);
        end
        GRANT_IP: app_st = tb_top.i_app_ip_rel ? GRANT_NONE : GRANT_IP;
        default: app_st = tb_top.i_app_cpu_rel ? GRANT_NONE : GRANT_CPU;
      endcase
      for (int i = 0; i < 3; i++) begin
        if (owner[i] == OWNER_IP && ip_rel[i]) begin
          owner[i] = OWNER_CPU;
        end else if (owner[i] == OWNER_CPU && cpu_rel[i]) begin
          owner[i] = OWNER_IP;
        end
      end
      if (tb_top.i_rx_len_wr) begin
        len = tb_top.i_rx_len_data;
      end
    end
  end

  task automatic report_tests();
    for (int t = 0; t < 6; t++) begin
      if (checks[t] == 0) begin
        errors[t]++;
        $display("test %s made no comparisons", names[t]);
      end else begin
        $display("test %s: %0d checks, %0d errors", names[t], checks[t], errors[t]);
      end
    end
  endtask

  function automatic int error_total();
    return errors.sum();
  endfunction

  function automatic int check_total();
    return checks.sum();
  endfunction

endmodule

//--- bench/tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import hub_types_pkg::*;

  localparam int TIMEOUT = 4000;

  logic clk = 1'b0;
  logic rst_n;
  logic i_ether_en, i_ros2_en;
  logic i_tx_wr_en, i_tx_rd_en, o_tx_full, o_tx_empty;
  logic i_rx_wr_en, i_rx_rd_en, o_rx_full, o_rx_empty;
  byte_t i_tx_din, o_tx_dout, i_rx_din, o_rx_dout;
  logic i_app_ip_req, i_app_ip_rel, i_app_cpu_req, i_app_cpu_rel;
  logic o_app_ip_grant, o_app_cpu_grant;
  logic i_apprx_ip_rel, i_apprx_cpu_rel, o_apprx_ip_grant, o_apprx_cpu_grant;
  logic i_rx_len_wr;
  app_len_t i_rx_len_data, o_rx_len;
  logic i_udprx_ip_rel, i_udprx_cpu_rel, o_udprx_ip_grant, o_udprx_cpu_grant;
  logic i_udptx_ip_rel, i_udptx_cpu_rel, o_udptx_ip_grant, o_udptx_cpu_grant;
  logic [31:0] rng = 32'd69;
  int wr_pct, rd_pct, ether_low, ros2_low, timed_out, errs;

  always #2 clk = ~clk;

  ros2_buffer_hub uut (.*);

  tb_checker u_checker ();

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic chance(input int pct);
    rng = xorshift(rng);
    return int'(rng % 32'd100) < pct;
  endfunction

  function automatic logic phase_done(input int kind, input int cycles);
    case (kind)
      0: return o_tx_full && o_rx_full;
      1: return o_tx_empty && o_rx_empty;
      default: return cycles >= 2000;
    endcase
  endfunction

  always @(posedge clk) begin
    if (rst_n) begin
      i_tx_wr_en <= chance(wr_pct);
      i_tx_din <= rng[7:0];
      i_tx_rd_en <= chance(rd_pct);
      i_rx_wr_en <= chance(wr_pct);
      i_rx_din <= rng[15:8];
      i_rx_rd_en <= chance(rd_pct);
      i_app_ip_req <= chance(30);
      i_app_cpu_req <= chance(30);
      i_app_ip_rel <= chance(15);
      i_app_cpu_rel <= chance(15);
      i_apprx_ip_rel <= chance(10);
      i_apprx_cpu_rel <= chance(10);
      i_udprx_ip_rel <= chance(10);
      i_udprx_cpu_rel <= chance(10);
      i_udptx_ip_rel <= chance(10);
      i_udptx_cpu_rel <= chance(10);
      i_rx_len_wr <= chance(10);
      i_rx_len_data <= app_len_t'(rng >> 8);
      // enables drop out for short random stretches
      if (ether_low > 0) begin
        ether_low = ether_low - 1;
      end else if (chance(2)) begin
        ether_low = 2 + int'(rng % 32'd10);
      end
      if (ros2_low > 0) begin
        ros2_low = ros2_low - 1;
      end else if (chance(2)) begin
        ros2_low = 2 + int'(rng % 32'd10);
      end
      i_ether_en <= (ether_low == 0);
      i_ros2_en <= (ros2_low == 0);
    end
  end

  // kind 0 runs until both queues fill, 1 until both drain, 2 for a fixed stretch
  task automatic run_phase(input string name, input int wr, input int rd, input int kind);
    int cycles;
    cycles = 0;
    wr_pct = wr;
    rd_pct = rd;
    while (!phase_done(kind, cycles)) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("phase %s did not reach its goal within %0d cycles", name, TIMEOUT);
        timed_out = 1;
        return;
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    {i_ether_en, i_ros2_en} = 2'b11;
    {i_tx_wr_en, i_tx_rd_en, i_rx_wr_en, i_rx_rd_en} = '0;
    {i_tx_din, i_rx_din, i_rx_len_data} = '0;
    {i_app_ip_req, i_app_ip_rel, i_app_cpu_req, i_app_cpu_rel} = '0;
    {i_apprx_ip_rel, i_apprx_cpu_rel, i_rx_len_wr} = '0;
    {i_udprx_ip_rel, i_udprx_cpu_rel, i_udptx_ip_rel, i_udptx_cpu_rel} = '0;
    {wr_pct, rd_pct, ether_low, ros2_low, timed_out} = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    run_phase("fill", 90, 10, 0);
    if (timed_out == 0) begin
      run_phase("drain", 10, 90, 1);
    end
    if (timed_out == 0) begin
      run_phase("mixed", 50, 50, 2);
    end
    repeat (2) @(negedge clk);
    u_checker.report_tests();
    errs = u_checker.error_total() + timed_out;
    $display("total: %0d checks, %0d errors", u_checker.check_total(), errs);
    if (errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- hdl/app_data_arbiter.sv
module app_data_arbiter (
  input  logic clk,
  input  logic rst_n,
  input  logic i_ether_en,
  input  logic i_ip_req,
  input  logic i_ip_rel,
  input  logic i_cpu_req,
  input  logic i_cpu_rel,
  output logic o_ip_grant,
  output logic o_cpu_grant
);
  import owner_pkg::*;

  app_grant_e state_q;

  // the core wins when both sides ask in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= GRANT_NONE;
    end else begin
      case (state_q)
        GRANT_NONE: begin
          if (i_ip_req) begin
            state_q <= GRANT_IP;
          end else if (i_cpu_req) begin
            state_q <= GRANT_CPU;
          end
        end
        GRANT_IP: begin
          if (i_ip_rel) begin
            state_q <= GRANT_NONE;
          end
        end
        GRANT_CPU: begin
          if (i_cpu_rel) begin
            state_q <= GRANT_NONE;
          end
        end
        default: begin
          state_q <= GRANT_NONE;
        end
      endcase
    end
  end

  // ownership is kept while the stack is off, only the grants drop
  assign o_ip_grant  = i_ether_en && (state_q == GRANT_IP);
  assign o_cpu_grant = i_ether_en && (state_q == GRANT_CPU);

  a_grants_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(o_ip_grant && o_cpu_grant)
  ) else $error("app data buffer granted to both core and cpu");

endmodule

//--- hdl/app_rx_handoff.sv
module app_rx_handoff (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_ros2_en,
  input  logic                    i_ip_rel,
  input  logic                    i_cpu_rel,
  input  logic                    i_rx_len_wr,
  input  hub_types_pkg::app_len_t i_rx_len_data,
  output logic                    o_ip_grant,
  output logic                    o_cpu_grant,
  output hub_types_pkg::app_len_t o_rx_len
);
  import hub_types_pkg::*;
  import owner_pkg::*;

  app_len_t rx_len_q;

  // the core fills the buffer first, then hands it to the cpu
  buffer_token #(
    .RESET_OWNER(OWNER_IP)
  ) u_rx_token (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_enable   (i_ros2_en),
    .i_ip_rel   (i_ip_rel),
    .i_cpu_rel  (i_cpu_rel),
    .o_ip_grant (o_ip_grant),
    .o_cpu_grant(o_cpu_grant)
  );

  // length of the message the core just wrote, read by the cpu later on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_len_q <= '0;
    end else if (i_rx_len_wr) begin
      rx_len_q <= i_rx_len_data;
    end
  end

  assign o_rx_len = rx_len_q;

endmodule

//--- hdl/buffer_token.sv
module buffer_token #(
  parameter owner_pkg::owner_e RESET_OWNER = owner_pkg::OWNER_IP
) (
  input  logic clk,
  input  logic rst_n,
  input  logic i_enable,
  input  logic i_ip_rel,
  input  logic i_cpu_rel,
  output logic o_ip_grant,
  output logic o_cpu_grant
);
  import owner_pkg::*;

  owner_e owner_q;

  // only the current owner can hand the buffer over
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= RESET_OWNER;
    end else begin
      case (owner_q)
        OWNER_IP: begin
          if (i_ip_rel) begin
            owner_q <= OWNER_CPU;
          end
        end
        OWNER_CPU: begin
          if (i_cpu_rel) begin
            owner_q <= OWNER_IP;
          end
        end
        default: begin
          owner_q <= RESET_OWNER;
        end
      endcase
    end
  end

  assign o_ip_grant  = i_enable && (owner_q == OWNER_IP);
  assign o_cpu_grant = i_enable && (owner_q == OWNER_CPU);

  a_grants_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(o_ip_grant && o_cpu_grant)
  ) else $error("buffer token granted to both sides");

endmodule

//--- hdl/byte_queue.sv
module byte_queue #(
  parameter int DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_wr_en,
  input  hub_types_pkg::byte_t i_din,
  output logic                 o_full,
  input  logic                 i_rd_en,
  output hub_types_pkg::byte_t o_dout,
  output logic                 o_empty
);
  import hub_types_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  byte_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // a push while full is dropped even when a pop happens in the same cycle
  assign push = i_wr_en && !o_full;
  assign pop  = i_rd_en && !o_empty;

  assign o_full  = (count_q == CNT_W'(DEPTH));
  assign o_empty = (count_q == '0);

  // first word fall through keeps the head always visible
  assign o_dout = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= i_din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // occupancy must stay within the memory
  a_count_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_q <= CNT_W'(DEPTH)
  ) else $error("byte_queue occupancy %0d above depth %0d", count_q, DEPTH);

endmodule

//--- hdl/hub_defs.svh
`ifndef HUB_DEFS_SVH
`define HUB_DEFS_SVH

// **************************************************
// queue depths between the protocol core and the IP stack
// **************************************************

// the core to stack queue holds one payload byte per entry
`define HUB_TX_QUEUE_DEPTH 16

// the stack to core queue is deeper since received frames arrive in bursts
`define HUB_RX_QUEUE_DEPTH 32

// **************************************************
// application buffer sizes
// **************************************************

// bits of a received application message length
`define HUB_APP_LEN_WIDTH 8

`endif

//--- hdl/hub_types_pkg.sv
`include "hub_defs.svh"

// **************************************************
// data and length types shared by the hub blocks
// **************************************************

package hub_types_pkg;

  // one payload byte as it moves through a queue
  typedef logic [7:0] byte_t;

  // length in bytes of the last received application message
  typedef logic [`HUB_APP_LEN_WIDTH-1:0] app_len_t;

endpackage

//--- hdl/owner_pkg.sv
// **************************************************
// ownership encodings for the shared buffers
// **************************************************

package owner_pkg;

  // owner of a ping-pong buffer
  typedef enum logic {
    OWNER_IP  = 1'b0,
    OWNER_CPU = 1'b1
  } owner_e;

  // state of the outgoing application data arbiter
  typedef enum logic [1:0] {
    GRANT_NONE = 2'b00,
    GRANT_IP   = 2'b01,
    GRANT_CPU  = 2'b10
  } app_grant_e;

endpackage

//--- hdl/ros2_buffer_hub.sv
`include "hub_defs.svh"

module ros2_buffer_hub (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_ether_en,
  input  logic                    i_ros2_en,

  // core to stack queue
  input  logic                    i_tx_wr_en,
  input  hub_types_pkg::byte_t    i_tx_din,
  output logic                    o_tx_full,
  input  logic                    i_tx_rd_en,
  output hub_types_pkg::byte_t    o_tx_dout,
  output logic                    o_tx_empty,

  // stack to core queue
  input  logic                    i_rx_wr_en,
  input  hub_types_pkg::byte_t    i_rx_din,
  output logic                    o_rx_full,
  input  logic                    i_rx_rd_en,
  output hub_types_pkg::byte_t    o_rx_dout,
  output logic                    o_rx_empty,

  // outgoing application data buffer
  input  logic                    i_app_ip_req,
  input  logic                    i_app_ip_rel,
  input  logic                    i_app_cpu_req,
  input  logic                    i_app_cpu_rel,
  output logic                    o_app_ip_grant,
  output logic                    o_app_cpu_grant,

  // received application data buffer
  input  logic                    i_apprx_ip_rel,
  input  logic                    i_apprx_cpu_rel,
  output logic                    o_apprx_ip_grant,
  output logic                    o_apprx_cpu_grant,
  input  logic                    i_rx_len_wr,
  input  hub_types_pkg::app_len_t i_rx_len_data,
  output hub_types_pkg::app_len_t o_rx_len,

  // UDP receive buffer
  input  logic                    i_udprx_ip_rel,
  input  logic                    i_udprx_cpu_rel,
  output logic                    o_udprx_ip_grant,
  output logic                    o_udprx_cpu_grant,

  // UDP transmit buffer
  input  logic                    i_udptx_ip_rel,
  input  logic                    i_udptx_cpu_rel,
  output logic                    o_udptx_ip_grant,
  output logic                    o_udptx_cpu_grant
);
  import owner_pkg::*;

  // **************************************************
  // byte queues between the core and the stack
  // **************************************************

  byte_queue #(
    .DEPTH(`HUB_TX_QUEUE_DEPTH)
  ) u_tx_queue (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_wr_en(i_tx_wr_en),
    .i_din  (i_tx_din),
    .o_full (o_tx_full),
    .i_rd_en(i_tx_rd_en),
    .o_dout (o_tx_dout),
    .o_empty(o_tx_empty)
  );

  byte_queue #(
    .DEPTH(`HUB_RX_QUEUE_DEPTH)
  ) u_rx_queue (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_wr_en(i_rx_wr_en),
    .i_din  (i_rx_din),
    .o_full (o_rx_full),
    .i_rd_en(i_rx_rd_en),
    .o_dout (o_rx_dout),
    .o_empty(o_rx_empty)
  );

  // **************************************************
  // buffer ownership
  // **************************************************

  app_data_arbiter u_app_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ether_en (i_ether_en),
    .i_ip_req   (i_app_ip_req),
    .i_ip_rel   (i_app_ip_rel),
    .i_cpu_req  (i_app_cpu_req),
    .i_cpu_rel  (i_app_cpu_rel),
    .o_ip_grant (o_app_ip_grant),
    .o_cpu_grant(o_app_cpu_grant)
  );

  // received messages are gated by the protocol core enable, not the stack
  app_rx_handoff u_app_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_ros2_en    (i_ros2_en),
    .i_ip_rel     (i_apprx_ip_rel),
    .i_cpu_rel    (i_apprx_cpu_rel),
    .i_rx_len_wr  (i_rx_len_wr),
    .i_rx_len_data(i_rx_len_data),
    .o_ip_grant   (o_apprx_ip_grant),
    .o_cpu_grant  (o_apprx_cpu_grant),
    .o_rx_len     (o_rx_len)
  );

  buffer_token #(
    .RESET_OWNER(OWNER_IP)
  ) u_udprx_token (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_enable   (i_ether_en),
    .i_ip_rel   (i_udprx_ip_rel),
    .i_cpu_rel  (i_udprx_cpu_rel),
    .o_ip_grant (o_udprx_ip_grant),
    .o_cpu_grant(o_udprx_cpu_grant)
  );

  // the cpu fills the transmit buffer first, so it owns it out of reset
  buffer_token #(
    .RESET_OWNER(OWNER_CPU)
  ) u_udptx_token (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_enable   (i_ether_en),
    .i_ip_rel   (i_udptx_ip_rel),
    .i_cpu_rel  (i_udptx_cpu_rel),
    .o_ip_grant (o_udptx_ip_grant),
    .o_cpu_grant(o_udptx_cpu_grant)
  );

endmodule

//--- sim.f
+incdir+hdl
hdl/hub_types_pkg.sv
hdl/owner_pkg.sv
hdl/byte_queue.sv
hdl/app_data_arbiter.sv
hdl/buffer_token.sv
hdl/app_rx_handoff.sv
hdl/ros2_buffer_hub.sv
bench/tb_checker.sv
bench/tb_top.sv
